// ==== logic/rv_isa_pkg.sv ====
`default_nettype none

package rv_isa_pkg;

	typedef logic [31:0] word_t;
	typedef logic [4:0] reg_idx_t;
	typedef logic [6:0] opcode_t;
	typedef logic [2:0] funct3_t;

	localparam word_t RESET_PC = 32'h0001_0000;

	// major opcodes
	localparam opcode_t OPC_LUI    = 7'b0110111;
	localparam opcode_t OPC_AUIPC  = 7'b0010111;
	localparam opcode_t OPC_JAL    = 7'b1101111;
	localparam opcode_t OPC_JALR   = 7'b1100111;
	localparam opcode_t OPC_BRANCH = 7'b1100011;
	localparam opcode_t OPC_LOAD   = 7'b0000011;
	localparam opcode_t OPC_STORE  = 7'b0100011;
	localparam opcode_t OPC_OP_IMM = 7'b0010011;
	localparam opcode_t OPC_OP     = 7'b0110011;

	localparam funct3_t F3_LB  = 3'b000;
	localparam funct3_t F3_LH  = 3'b001;
	localparam funct3_t F3_LW  = 3'b010;
	localparam funct3_t F3_LBU = 3'b100;
	localparam funct3_t F3_LHU = 3'b101;

	localparam funct3_t F3_SB = 3'b000;
	localparam funct3_t F3_SH = 3'b001;
	localparam funct3_t F3_SW = 3'b010;

	localparam funct3_t F3_BEQ  = 3'b000;
	localparam funct3_t F3_BNE  = 3'b001;
	localparam funct3_t F3_BLT  = 3'b100;
	localparam funct3_t F3_BGE  = 3'b101;
	localparam funct3_t F3_BLTU = 3'b110;
	localparam funct3_t F3_BGEU = 3'b111;

	localparam funct3_t F3_ADD_SUB = 3'b000; // sub only for OP with ir[30]
	localparam funct3_t F3_SLL     = 3'b001;
	localparam funct3_t F3_SLT     = 3'b010;
	localparam funct3_t F3_SLTU    = 3'b011;
	localparam funct3_t F3_XOR     = 3'b100;
	localparam funct3_t F3_SRL_SRA = 3'b101; // ir[30] picks arithmetic
	localparam funct3_t F3_OR      = 3'b110;
	localparam funct3_t F3_AND     = 3'b111;

endpackage

`default_nettype wire

// ==== logic/core_ctrl_pkg.sv ====
`default_nettype none

package core_ctrl_pkg;

	typedef enum logic [3:0] {
		ALU_OP_ADD,
		ALU_OP_SUB,
		ALU_OP_SLL,
		ALU_OP_SLT,
		ALU_OP_SLTU,
		ALU_OP_XOR,
		ALU_OP_SRL,
		ALU_OP_SRA,
		ALU_OP_OR,
		ALU_OP_AND
	} alu_op_t;

	typedef enum logic [2:0] {
		CMP_OP_EQ,
		CMP_OP_NE,
		CMP_OP_LT,
		CMP_OP_GE,
		CMP_OP_LTU,
		CMP_OP_GEU
	} cmp_op_t;

	typedef enum logic [1:0] {
		NEXT_PC_SEL_PC_4,
		NEXT_PC_SEL_ALU_OUT,
		NEXT_PC_SEL_CMP_RESULT // alu_out if taken, else pc+4
	} next_pc_sel_t;

	typedef enum logic [2:0] {
		REGFILE_IN_SEL_ALU_OUT,
		REGFILE_IN_SEL_PC_4,
		REGFILE_IN_SEL_MEM_RD,
		REGFILE_IN_SEL_MEM_RD_SEXT8,
		REGFILE_IN_SEL_MEM_RD_SEXT16
	} regfile_in_sel_t;

	typedef enum logic {
		MEM_RD_ADDR_SEL_PC,
		MEM_RD_ADDR_SEL_ALU_OUT
	} mem_rd_addr_sel_t;

	typedef enum logic [1:0] {
		ALU_IN1_SEL_RS1,
		ALU_IN1_SEL_PC,
		ALU_IN1_SEL_ZERO
	} alu_in1_sel_t;

	typedef enum logic [2:0] {
		ALU_IN2_SEL_RS2,
		ALU_IN2_SEL_U_IMM,
		ALU_IN2_SEL_I_IMM,
		ALU_IN2_SEL_J_IMM,
		ALU_IN2_SEL_B_IMM,
		ALU_IN2_SEL_S_IMM
	} alu_in2_sel_t;

	typedef enum logic [1:0] {
		MEM_SIZE_BYTE,
		MEM_SIZE_HALF,
		MEM_SIZE_WORD
	} mem_size_t;

	typedef enum logic [1:0] {
		STATE_FETCH,
		STATE_EXECUTE,
		STATE_MEMORY // loads only
	} ctrl_state_t;

endpackage

`default_nettype wire

// ==== logic/control.sv ====
`timescale 1ns/10ps
`default_nettype none

module control (
	input  logic                               clk_i,
	input  logic                               reset_i,
	input  rv_isa_pkg::word_t                  ir_i,
	output logic                               pc_we_o,
	output logic                               ir_we_o,
	output logic                               regfile_we_o,
	output logic                               mem_wr_enable_o,
	output core_ctrl_pkg::next_pc_sel_t        next_pc_sel_o,
	output core_ctrl_pkg::regfile_in_sel_t     regfile_in_sel_o,
	output core_ctrl_pkg::mem_rd_addr_sel_t    mem_rd_addr_sel_o,
	output core_ctrl_pkg::alu_in1_sel_t        alu_in1_sel_o,
	output core_ctrl_pkg::alu_in2_sel_t        alu_in2_sel_o,
	output core_ctrl_pkg::alu_op_t             alu_op_o,
	output core_ctrl_pkg::cmp_op_t             cmp_op_o,
	output core_ctrl_pkg::mem_size_t           mem_rd_size_o,
	output logic                               mem_rd_unsigned_o,
	output core_ctrl_pkg::mem_size_t           mem_wr_size_o
);
	import rv_isa_pkg::*;
	import core_ctrl_pkg::*;

	ctrl_state_t state;
	ctrl_state_t state_next;
	opcode_t     opcode;
	funct3_t     funct3;
	logic        alt_op;

	assign opcode = ir_i[6:0];
	assign funct3 = ir_i[14:12];
	assign alt_op = ir_i[30];

	function automatic alu_op_t arith_op(input funct3_t f3, input logic sub, input logic sra);
		case (f3)
		F3_ADD_SUB: return sub ? ALU_OP_SUB : ALU_OP_ADD;
		F3_SLL:     return ALU_OP_SLL;
		F3_SLT:     return ALU_OP_SLT;
		F3_SLTU:    return ALU_OP_SLTU;
		F3_XOR:     return ALU_OP_XOR;
		F3_SRL_SRA: return sra ? ALU_OP_SRA : ALU_OP_SRL;
		F3_OR:      return ALU_OP_OR;
		default:    return ALU_OP_AND;
		endcase
	endfunction

	function automatic cmp_op_t branch_op(input funct3_t f3);
		case (f3)
		F3_BEQ:  return CMP_OP_EQ;
		F3_BNE:  return CMP_OP_NE;
		F3_BLT:  return CMP_OP_LT;
		F3_BGE:  return CMP_OP_GE;
		F3_BLTU: return CMP_OP_LTU;
		F3_BGEU: return CMP_OP_GEU;
		default: return CMP_OP_EQ; // reserved funct3 codes decode as beq
		endcase
	endfunction

	function automatic mem_size_t access_size(input funct3_t f3);
		case (f3)
		F3_LB, F3_LBU: return MEM_SIZE_BYTE; // same codes as SB/SH/SW in bits 1:0
		F3_LH, F3_LHU: return MEM_SIZE_HALF;
		F3_LW:         return MEM_SIZE_WORD;
		default:       return MEM_SIZE_WORD;
		endcase
	endfunction

	function automatic mem_size_t store_size(input funct3_t f3);
		case (f3)
		F3_SB:   return MEM_SIZE_BYTE;
		F3_SH:   return MEM_SIZE_HALF;
		F3_SW:   return MEM_SIZE_WORD;
		default: return MEM_SIZE_WORD;
		endcase
	endfunction

	always_ff @(posedge clk_i) begin
		if (reset_i)
			state <= STATE_FETCH;
		else
			state <= state_next;
	end

	always_comb begin
		state_next        = STATE_FETCH;
		pc_we_o           = 1'b0;
		ir_we_o           = 1'b0;
		regfile_we_o      = 1'b0;
		mem_wr_enable_o   = 1'b0;
		next_pc_sel_o     = NEXT_PC_SEL_PC_4;
		regfile_in_sel_o  = REGFILE_IN_SEL_ALU_OUT;
		mem_rd_addr_sel_o = MEM_RD_ADDR_SEL_PC;
		alu_in1_sel_o     = ALU_IN1_SEL_RS1;
		alu_in2_sel_o     = ALU_IN2_SEL_I_IMM; // rs1 + imm_i also forms the load address
		alu_op_o          = ALU_OP_ADD;
		cmp_op_o          = branch_op(funct3);
		mem_rd_size_o     = MEM_SIZE_WORD;
		mem_rd_unsigned_o = 1'b0;
		mem_wr_size_o     = store_size(funct3);

		case (state)
		STATE_FETCH: begin
			ir_we_o    = 1'b1;
			state_next = STATE_EXECUTE;
		end
		STATE_EXECUTE: begin
			pc_we_o = 1'b1;
			case (opcode)
			OPC_LUI: begin
				alu_in1_sel_o = ALU_IN1_SEL_ZERO;
				alu_in2_sel_o = ALU_IN2_SEL_U_IMM;
				regfile_we_o  = 1'b1;
			end
			OPC_AUIPC: begin
				alu_in1_sel_o = ALU_IN1_SEL_PC;
				alu_in2_sel_o = ALU_IN2_SEL_U_IMM;
				regfile_we_o  = 1'b1;
			end
			OPC_JAL: begin
				alu_in1_sel_o    = ALU_IN1_SEL_PC;
				alu_in2_sel_o    = ALU_IN2_SEL_J_IMM;
				next_pc_sel_o    = NEXT_PC_SEL_ALU_OUT;
				regfile_in_sel_o = REGFILE_IN_SEL_PC_4; // link
				regfile_we_o     = 1'b1;
			end
			OPC_JALR: begin
				next_pc_sel_o    = NEXT_PC_SEL_ALU_OUT;
				regfile_in_sel_o = REGFILE_IN_SEL_PC_4;
				regfile_we_o     = 1'b1;
			end
			OPC_BRANCH: begin
				alu_in1_sel_o = ALU_IN1_SEL_PC;
				alu_in2_sel_o = ALU_IN2_SEL_B_IMM;
				next_pc_sel_o = NEXT_PC_SEL_CMP_RESULT;
			end
			OPC_LOAD: begin
				pc_we_o    = 1'b0; // pc moves at the end of MEMORY
				state_next = STATE_MEMORY;
			end
			OPC_STORE: begin
				alu_in2_sel_o   = ALU_IN2_SEL_S_IMM;
				mem_wr_enable_o = 1'b1;
			end
			OPC_OP_IMM: begin
				alu_op_o     = arith_op(funct3, 1'b0, alt_op);
				regfile_we_o = 1'b1;
			end
			OPC_OP: begin
				alu_in2_sel_o = ALU_IN2_SEL_RS2;
				alu_op_o      = arith_op(funct3, alt_op, alt_op);
				regfile_we_o  = 1'b1;
			end
			default: begin
				next_pc_sel_o = NEXT_PC_SEL_PC_4; // unknown opcode goes on to pc+4
			end
			endcase
		end
		STATE_MEMORY: begin
			mem_rd_addr_sel_o = MEM_RD_ADDR_SEL_ALU_OUT;
			mem_rd_size_o     = access_size(funct3);
			mem_rd_unsigned_o = (funct3 == F3_LBU) || (funct3 == F3_LHU);
			regfile_we_o      = 1'b1;
			pc_we_o           = 1'b1;
			if (funct3 == F3_LB)
				regfile_in_sel_o = REGFILE_IN_SEL_MEM_RD_SEXT8;
			else if (funct3 == F3_LH)
				regfile_in_sel_o = REGFILE_IN_SEL_MEM_RD_SEXT16;
			else
				regfile_in_sel_o = REGFILE_IN_SEL_MEM_RD;
		end
		default: begin
			state_next = STATE_FETCH;
		end
		endcase
	end

endmodule

`default_nettype wire

// ==== logic/regfile.sv ====
`timescale 1ns/10ps
`default_nettype none

module regfile (
	input  logic                  clk_i,
	input  rv_isa_pkg::reg_idx_t  rs1_i,
	input  rv_isa_pkg::reg_idx_t  rs2_i,
	input  rv_isa_pkg::reg_idx_t  rd_i,
	input  rv_isa_pkg::word_t     rin_i,
	input  logic                  we_i,
	output rv_isa_pkg::word_t     rout1_o,
	output rv_isa_pkg::word_t     rout2_o
);
	import rv_isa_pkg::*;

	word_t regs [32];

	always_ff @(posedge clk_i) begin
		if (we_i && (rd_i != '0))
			regs[rd_i] <= rin_i;
	end

	// x0 is never stored, so its read is forced
	assign rout1_o = (rs1_i == '0) ? '0 : regs[rs1_i];
	assign rout2_o = (rs2_i == '0) ? '0 : regs[rs2_i];

endmodule

`default_nettype wire

// ==== logic/alu.sv ====
`timescale 1ns/10ps
`default_nettype none

module alu (
	input  core_ctrl_pkg::alu_op_t  alu_op_i,
	input  rv_isa_pkg::word_t       in1_i,
	input  rv_isa_pkg::word_t       in2_i,
	output rv_isa_pkg::word_t       out_o
);
	import rv_isa_pkg::*;
	import core_ctrl_pkg::*;

	logic [4:0] shamt;

	assign shamt = in2_i[4:0];

	always_comb begin
		case (alu_op_i)
		ALU_OP_ADD:
			out_o = in1_i + in2_i;
		ALU_OP_SUB:
			out_o = in1_i - in2_i;
		ALU_OP_SLL:
			out_o = in1_i << shamt;
		ALU_OP_SLT:
			out_o = word_t'($signed(in1_i) < $signed(in2_i));
		ALU_OP_SLTU:
			out_o = word_t'(in1_i < in2_i);
		ALU_OP_XOR:
			out_o = in1_i ^ in2_i;
		ALU_OP_SRL:
			out_o = in1_i >> shamt;
		ALU_OP_SRA:
			out_o = word_t'($signed(in1_i) >>> shamt);
		ALU_OP_OR:
			out_o = in1_i | in2_i;
		default:
			out_o = in1_i & in2_i; // and
		endcase
	end

endmodule

`default_nettype wire

// ==== logic/compare_unit.sv ====
`timescale 1ns/10ps
`default_nettype none

module compare_unit (
	input  core_ctrl_pkg::cmp_op_t  cmp_op_i,
	input  rv_isa_pkg::word_t       in1_i,
	input  rv_isa_pkg::word_t       in2_i,
	output logic                    res_o
);
	import core_ctrl_pkg::*;

	logic eq;
	logic lt;
	logic ltu;

	assign eq  = (in1_i == in2_i);
	assign lt  = ($signed(in1_i) < $signed(in2_i));
	assign ltu = (in1_i < in2_i);

	always_comb begin
		case (cmp_op_i)
		CMP_OP_EQ:  res_o = eq;
		CMP_OP_NE:  res_o = !eq;
		CMP_OP_LT:  res_o = lt;
		CMP_OP_GE:  res_o = !lt;
		CMP_OP_LTU: res_o = ltu;
		CMP_OP_GEU: res_o = !ltu;
		default:    res_o = 1'b0;
		endcase
	end

endmodule

`default_nettype wire

// ==== logic/datapath.sv ====
`timescale 1ns/10ps
`default_nettype none

module datapath (
	input  logic                       clk_i,
	input  logic                       reset_i,
	output rv_isa_pkg::word_t          mem_rd_addr_o,
	output core_ctrl_pkg::mem_size_t   mem_rd_size_o,
	output logic                       mem_rd_unsigned_o,
	input  rv_isa_pkg::word_t          mem_rd_data_i,
	output logic                       mem_wr_enable_o,
	output rv_isa_pkg::word_t          mem_wr_addr_o,
	output rv_isa_pkg::word_t          mem_wr_data_o,
	output core_ctrl_pkg::mem_size_t   mem_wr_size_o
);
	import rv_isa_pkg::*;
	import core_ctrl_pkg::*;

	word_t pc;
	word_t ir;

	reg_idx_t rs1_idx;
	reg_idx_t rs2_idx;
	reg_idx_t rd_idx;

	word_t imm_i;
	word_t imm_s;
	word_t imm_b;
	word_t imm_u;
	word_t imm_j;

	word_t pc_plus4;
	word_t jump_target;
	word_t next_pc;
	word_t alu_in1;
	word_t alu_in2;
	word_t alu_out;
	word_t rf_rin;
	word_t rf_rout1;
	word_t rf_rout2;
	logic  cmp_res;

	logic             ctrl_pc_we;
	logic             ctrl_ir_we;
	logic             ctrl_regfile_we;
	next_pc_sel_t     ctrl_next_pc_sel;
	regfile_in_sel_t  ctrl_regfile_in_sel;
	mem_rd_addr_sel_t ctrl_mem_rd_addr_sel;
	alu_in1_sel_t     ctrl_alu_in1_sel;
	alu_in2_sel_t     ctrl_alu_in2_sel;
	alu_op_t          ctrl_alu_op;
	cmp_op_t          ctrl_cmp_op;

	assign rs1_idx = ir[19:15];
	assign rs2_idx = ir[24:20];
	assign rd_idx  = ir[11:7];

	assign imm_i = {{20{ir[31]}}, ir[31:20]};
	assign imm_s = {{20{ir[31]}}, ir[31:25], ir[11:7]};
	assign imm_b = {{19{ir[31]}}, ir[31], ir[7], ir[30:25], ir[11:8], 1'b0};
	assign imm_u = {ir[31:12], 12'b0};
	assign imm_j = {{11{ir[31]}}, ir[31], ir[19:12], ir[20], ir[30:21], 1'b0};

	assign pc_plus4    = pc + 32'd4;
	assign jump_target = {alu_out[31:1], 1'b0}; // jalr clears bit 0

	control u_control (
		.clk_i             (clk_i),
		.reset_i           (reset_i),
		.ir_i              (ir),
		.pc_we_o           (ctrl_pc_we),
		.ir_we_o           (ctrl_ir_we),
		.regfile_we_o      (ctrl_regfile_we),
		.mem_wr_enable_o   (mem_wr_enable_o),
		.next_pc_sel_o     (ctrl_next_pc_sel),
		.regfile_in_sel_o  (ctrl_regfile_in_sel),
		.mem_rd_addr_sel_o (ctrl_mem_rd_addr_sel),
		.alu_in1_sel_o     (ctrl_alu_in1_sel),
		.alu_in2_sel_o     (ctrl_alu_in2_sel),
		.alu_op_o          (ctrl_alu_op),
		.cmp_op_o          (ctrl_cmp_op),
		.mem_rd_size_o     (mem_rd_size_o),
		.mem_rd_unsigned_o (mem_rd_unsigned_o),
		.mem_wr_size_o     (mem_wr_size_o)
	);

	regfile u_regfile (
		.clk_i   (clk_i),
		.rs1_i   (rs1_idx),
		.rs2_i   (rs2_idx),
		.rd_i    (rd_idx),
		.rin_i   (rf_rin),
		.we_i    (ctrl_regfile_we),
		.rout1_o (rf_rout1),
		.rout2_o (rf_rout2)
	);

	alu u_alu (
		.alu_op_i (ctrl_alu_op),
		.in1_i    (alu_in1),
		.in2_i    (alu_in2),
		.out_o    (alu_out)
	);

	compare_unit u_cmp (
		.cmp_op_i (ctrl_cmp_op),
		.in1_i    (rf_rout1),
		.in2_i    (rf_rout2),
		.res_o    (cmp_res)
	);

	assign mem_wr_addr_o = alu_out;
	assign mem_wr_data_o = rf_rout2; // memory keeps only the low bytes for sb/sh

	always_comb begin
		case (ctrl_next_pc_sel)
		NEXT_PC_SEL_ALU_OUT:    next_pc = jump_target;
		NEXT_PC_SEL_CMP_RESULT: next_pc = cmp_res ? jump_target : pc_plus4;
		default:                next_pc = pc_plus4;
		endcase

		case (ctrl_regfile_in_sel)
		REGFILE_IN_SEL_PC_4:          rf_rin = pc_plus4;
		REGFILE_IN_SEL_MEM_RD:        rf_rin = mem_rd_data_i;
		REGFILE_IN_SEL_MEM_RD_SEXT8:  rf_rin = {{24{mem_rd_data_i[7]}}, mem_rd_data_i[7:0]};
		REGFILE_IN_SEL_MEM_RD_SEXT16: rf_rin = {{16{mem_rd_data_i[15]}}, mem_rd_data_i[15:0]};
		default:                      rf_rin = alu_out;
		endcase

		case (ctrl_mem_rd_addr_sel)
		MEM_RD_ADDR_SEL_ALU_OUT: mem_rd_addr_o = alu_out;
		default:                 mem_rd_addr_o = pc;
		endcase

		case (ctrl_alu_in1_sel)
		ALU_IN1_SEL_PC:   alu_in1 = pc;
		ALU_IN1_SEL_ZERO: alu_in1 = '0; // lui
		default:          alu_in1 = rf_rout1;
		endcase

		case (ctrl_alu_in2_sel)
		ALU_IN2_SEL_U_IMM: alu_in2 = imm_u;
		ALU_IN2_SEL_I_IMM: alu_in2 = imm_i;
		ALU_IN2_SEL_J_IMM: alu_in2 = imm_j;
		ALU_IN2_SEL_B_IMM: alu_in2 = imm_b;
		ALU_IN2_SEL_S_IMM: alu_in2 = imm_s;
		default:           alu_in2 = rf_rout2;
		endcase
	end

	always_ff @(posedge clk_i) begin
		if (reset_i) begin
			pc <= RESET_PC;
			ir <= '0;
		end else begin
			if (ctrl_pc_we)
				pc <= next_pc;
			if (ctrl_ir_we)
				ir <= mem_rd_data_i;
		end
	end

endmodule

`default_nettype wire

// ==== tests/datapath_chk.sv ====
`timescale 1ns/10ps
`default_nettype none

module datapath_chk (
	input  logic                       clk_i,
	input  logic                       reset_i,
	input  core_ctrl_pkg::ctrl_state_t state_i,
	input  rv_isa_pkg::word_t          pc_i,
	input  rv_isa_pkg::word_t          mem_rd_addr_i,
	input  logic                       ir_we_i,
	input  logic                       regfile_we_i,
	input  logic                       mem_wr_enable_i
);
	import core_ctrl_pkg::*;

	// fetch only reads, it never writes anything back
	a_fetch_quiet: assert property (@(posedge clk_i) disable iff (reset_i)
		(state_i == STATE_FETCH) |-> (!mem_wr_enable_i && !regfile_we_i))
		else $error("write strobe active in fetch state");

	a_pc_aligned: assert property (@(posedge clk_i) disable iff (reset_i)
		pc_i[1:0] == 2'b00)
		else $error("pc not word aligned");

	a_wr_single: assert property (@(posedge clk_i) disable iff (reset_i)
		mem_wr_enable_i |=> !mem_wr_enable_i)
		else $error("mem write enable held for two cycles");

	a_fetch_addr: assert property (@(posedge clk_i) disable iff (reset_i)
		ir_we_i |-> (mem_rd_addr_i == pc_i))
		else $error("instruction fetched from an address other than pc");

endmodule

`default_nettype wire

// ==== tests/datapath_tb.sv ====
`timescale 1ns/10ps
`default_nettype none

module datapath_tb;
	import rv_isa_pkg::*;
	import core_ctrl_pkg::*;

	localparam int MEM_BYTES = 1024;
	localparam word_t DATA_BASE = RESET_PC + 32'h200;

	logic      clk;
	logic      reset;
	word_t     mem_rd_addr;
	mem_size_t mem_rd_size;
	logic      mem_rd_unsigned;
	word_t     mem_rd_data;
	logic      mem_wr_enable;
	word_t     mem_wr_addr;
	word_t     mem_wr_data;
	mem_size_t mem_wr_size;

	logic [7:0] mem [MEM_BYTES];
	word_t      prog_q [$];
	word_t      exp_addr_q [$];
	word_t      exp_data_q [$];
	mem_size_t  exp_size_q [$];
	word_t      obs_addr_q [$];
	word_t      obs_data_q [$];
	mem_size_t  obs_size_q [$];
	word_t      ld_addr_q [$];
	mem_size_t  ld_size_q [$];
	logic       ld_unsigned_q [$];
	int         load_count;

	datapath u_datapath (
		.clk_i             (clk),
		.reset_i           (reset),
		.mem_rd_addr_o     (mem_rd_addr),
		.mem_rd_size_o     (mem_rd_size),
		.mem_rd_unsigned_o (mem_rd_unsigned),
		.mem_rd_data_i     (mem_rd_data),
		.mem_wr_enable_o   (mem_wr_enable),
		.mem_wr_addr_o     (mem_wr_addr),
		.mem_wr_data_o     (mem_wr_data),
		.mem_wr_size_o     (mem_wr_size)
	);

	bind datapath datapath_chk u_chk (
		.clk_i           (clk_i),
		.reset_i         (reset_i),
		.state_i         (u_control.state),
		.pc_i            (pc),
		.mem_rd_addr_i   (mem_rd_addr_o),
		.ir_we_i         (ctrl_ir_we),
		.regfile_we_i    (ctrl_regfile_we),
		.mem_wr_enable_i (mem_wr_enable_o)
	);

	always #4 clk = ~clk;

	function automatic word_t enc_r(int f7, int f3, int rd, int rs1, int rs2);
		return {f7[6:0], rs2[4:0], rs1[4:0], f3[2:0], rd[4:0], OPC_OP};
	endfunction

	function automatic word_t enc_i(opcode_t op, int f3, int rd, int rs1, int imm);
		return {imm[11:0], rs1[4:0], f3[2:0], rd[4:0], op};
	endfunction

	function automatic word_t enc_s(int f3, int rs2, int rs1, int imm);
		return {imm[11:5], rs2[4:0], rs1[4:0], f3[2:0], imm[4:0], OPC_STORE};
	endfunction

	function automatic word_t enc_b(int f3, int rs1, int rs2, int imm);
		return {imm[12], imm[10:5], rs2[4:0], rs1[4:0], f3[2:0], imm[4:1], imm[11], OPC_BRANCH};
	endfunction

	function automatic word_t enc_u(opcode_t op, int rd, int imm20);
		return {imm20[19:0], rd[4:0], op};
	endfunction

	function automatic word_t enc_j(int rd, int imm);
		return {imm[20], imm[10:1], imm[11], imm[19:12], rd[4:0], OPC_JAL};
	endfunction

	function automatic int byte_index(word_t addr);
		word_t off;
		off = addr - RESET_PC;
		return int'(off[9:0]);
	endfunction

	function automatic word_t size_mask(mem_size_t size);
		case (size)
		MEM_SIZE_BYTE: return 32'h0000_00ff;
		MEM_SIZE_HALF: return 32'h0000_ffff;
		default:       return 32'hffff_ffff;
		endcase
	endfunction

	// little endian, upper bits zero filled
	always_comb begin
		int i;
		i = byte_index(mem_rd_addr);
		mem_rd_data = {mem[(i + 3) % MEM_BYTES], mem[(i + 2) % MEM_BYTES],
			mem[(i + 1) % MEM_BYTES], mem[i]} & size_mask(mem_rd_size);
	end

	always @(posedge clk) begin : mem_write
		int i;
		if (!reset && mem_wr_enable) begin
			i = byte_index(mem_wr_addr);
			mem[i] <= mem_wr_data[7:0];
			if (mem_wr_size != MEM_SIZE_BYTE)
				mem[(i + 1) % MEM_BYTES] <= mem_wr_data[15:8];
			if (mem_wr_size == MEM_SIZE_WORD) begin
				mem[(i + 2) % MEM_BYTES] <= mem_wr_data[23:16];
				mem[(i + 3) % MEM_BYTES] <= mem_wr_data[31:24];
			end
			obs_addr_q.push_back(mem_wr_addr);
			obs_data_q.push_back(mem_wr_data);
			obs_size_q.push_back(mem_wr_size);
		end
	end

	task automatic expect_store(word_t addr, word_t data, mem_size_t size);
		exp_addr_q.push_back(addr);
		exp_data_q.push_back(data);
		exp_size_q.push_back(size);
	endtask

	task automatic expect_load(word_t addr, mem_size_t size, logic is_unsigned);
		ld_addr_q.push_back(addr);
		ld_size_q.push_back(size);
		ld_unsigned_q.push_back(is_unsigned);
	endtask

	task automatic check_value(string name, word_t got, word_t exp);
		assert (got == exp) else begin
			$display("** Error: %s = %h, expected %h", name, got, exp);
			$display(">>> FAIL");
			$fatal(1, "value mismatch");
		end
	endtask

	// only loads read the data area
	always @(negedge clk) begin
		if (!reset && (mem_rd_addr >= DATA_BASE)) begin
			assert (load_count < ld_addr_q.size()) else begin
				$display("a data read happened that matches no expected load");
				$display(">>> FAIL");
				$fatal(1, "unexpected load");
			end
			check_value("mem_rd_addr_o", mem_rd_addr, ld_addr_q[load_count]);
			check_value("mem_rd_size_o", word_t'(mem_rd_size), word_t'(ld_size_q[load_count]));
			check_value("mem_rd_unsigned_o", word_t'(mem_rd_unsigned),
				word_t'(ld_unsigned_q[load_count]));
			load_count++;
		end
	end

	task automatic load_program();
		int i;
		// x1 data base, x2 = -5, x3 = 7
		prog_q.push_back(enc_u(OPC_LUI, 1, 32'h10));
		prog_q.push_back(enc_i(OPC_OP_IMM, F3_ADD_SUB, 1, 1, 32'h200));
		prog_q.push_back(enc_i(OPC_OP_IMM, F3_ADD_SUB, 2, 0, -5));
		prog_q.push_back(enc_s(F3_SW, 2, 1, 0));
		prog_q.push_back(enc_i(OPC_OP_IMM, F3_ADD_SUB, 3, 0, 7));
		prog_q.push_back(enc_r(32'h20, F3_ADD_SUB, 4, 3, 2)); // sub
		prog_q.push_back(enc_s(F3_SW, 4, 1, 4));
		prog_q.push_back(enc_i(OPC_OP_IMM, F3_SLL, 5, 3, 4));
		prog_q.push_back(enc_i(OPC_OP_IMM, F3_SRL_SRA, 6, 2, 32'h401)); // srai 1
		prog_q.push_back(enc_i(OPC_OP_IMM, F3_SRL_SRA, 7, 2, 28));
		prog_q.push_back(enc_s(F3_SW, 5, 1, 8));
		prog_q.push_back(enc_s(F3_SW, 6, 1, 12));
		prog_q.push_back(enc_s(F3_SW, 7, 1, 16));
		prog_q.push_back(enc_r(0, F3_SLT, 8, 2, 3));
		prog_q.push_back(enc_r(0, F3_SLTU, 9, 2, 3));
		prog_q.push_back(enc_r(0, F3_XOR, 10, 2, 3));
		prog_q.push_back(enc_r(0, F3_OR, 11, 2, 3));
		prog_q.push_back(enc_r(0, F3_AND, 12, 2, 3));
		for (i = 0; i < 5; i++)
			prog_q.push_back(enc_s(F3_SW, 8 + i, 1, 20 + 4 * i));
		prog_q.push_back(enc_u(OPC_AUIPC, 13, 1));
		prog_q.push_back(enc_s(F3_SW, 13, 1, 40));
		prog_q.push_back(enc_i(OPC_LOAD, F3_LB, 14, 1, 0));
		prog_q.push_back(enc_s(F3_SW, 14, 1, 44));
		prog_q.push_back(enc_i(OPC_LOAD, F3_LH, 15, 1, 0));
		prog_q.push_back(enc_s(F3_SW, 15, 1, 48));
		prog_q.push_back(enc_i(OPC_LOAD, F3_LBU, 16, 1, 0));
		prog_q.push_back(enc_s(F3_SW, 16, 1, 52));
		prog_q.push_back(enc_i(OPC_LOAD, F3_LHU, 17, 1, 0));
		prog_q.push_back(enc_s(F3_SW, 17, 1, 56));
		prog_q.push_back(enc_i(OPC_LOAD, F3_LW, 18, 1, 4));
		prog_q.push_back(enc_s(F3_SW, 18, 1, 60));
		// each kind goes not taken, then taken over a bad store, then a marker store
		prog_q.push_back(enc_b(F3_BEQ, 2, 3, 8));
		prog_q.push_back(enc_b(F3_BEQ, 3, 3, 8));
		prog_q.push_back(enc_s(F3_SW, 2, 1, 128));
		prog_q.push_back(enc_s(F3_SW, 3, 1, 64));
		prog_q.push_back(enc_b(F3_BNE, 3, 3, 8));
		prog_q.push_back(enc_b(F3_BNE, 2, 3, 8));
		prog_q.push_back(enc_s(F3_SW, 2, 1, 128));
		prog_q.push_back(enc_s(F3_SW, 3, 1, 68));
		prog_q.push_back(enc_b(F3_BLT, 3, 2, 8));
		prog_q.push_back(enc_b(F3_BLT, 2, 3, 8));
		prog_q.push_back(enc_s(F3_SW, 2, 1, 128));
		prog_q.push_back(enc_s(F3_SW, 3, 1, 72));
		prog_q.push_back(enc_b(F3_BGE, 2, 3, 8));
		prog_q.push_back(enc_b(F3_BGE, 3, 2, 8));
		prog_q.push_back(enc_s(F3_SW, 2, 1, 128));
		prog_q.push_back(enc_s(F3_SW, 3, 1, 76));
		prog_q.push_back(enc_b(F3_BLTU, 2, 3, 8));
		prog_q.push_back(enc_b(F3_BLTU, 3, 2, 8));
		prog_q.push_back(enc_s(F3_SW, 2, 1, 128));
		prog_q.push_back(enc_s(F3_SW, 3, 1, 80));
		prog_q.push_back(enc_b(F3_BGEU, 3, 2, 8));
		prog_q.push_back(enc_b(F3_BGEU, 2, 3, 8));
		prog_q.push_back(enc_s(F3_SW, 2, 1, 128));
		prog_q.push_back(enc_s(F3_SW, 3, 1, 84));
		prog_q.push_back(enc_j(19, 8));
		prog_q.push_back(enc_s(F3_SW, 2, 1, 128));
		prog_q.push_back(enc_s(F3_SW, 19, 1, 88));
		prog_q.push_back(enc_u(OPC_AUIPC, 20, 0));
		prog_q.push_back(enc_i(OPC_JALR, 0, 21, 20, 12));
		prog_q.push_back(enc_s(F3_SW, 2, 1, 128));
		prog_q.push_back(enc_s(F3_SW, 21, 1, 92));
		prog_q.push_back(enc_s(F3_SW, 4, 1, 96));
		prog_q.push_back(enc_s(F3_SB, 10, 1, 97));
		prog_q.push_back(enc_s(F3_SH, 7, 1, 98));
		prog_q.push_back(enc_i(OPC_LOAD, F3_LW, 22, 1, 96));
		prog_q.push_back(enc_s(F3_SW, 22, 1, 100));
		prog_q.push_back(enc_i(OPC_OP_IMM, F3_ADD_SUB, 0, 0, 5));
		prog_q.push_back(enc_s(F3_SW, 0, 1, 104));
		prog_q.push_back(enc_j(0, 0)); // park here
		for (i = 0; i < MEM_BYTES; i++)
			mem[i] = 8'(i ^ (i >> 8));
		for (i = 0; i < prog_q.size(); i++)
			{mem[4 * i + 3], mem[4 * i + 2], mem[4 * i + 1], mem[4 * i]} = prog_q[i];
	endtask

	task automatic load_expected();
		expect_store(32'h0001_0200, 32'hffff_fffb, MEM_SIZE_WORD);
		expect_store(32'h0001_0204, 32'h0000_000c, MEM_SIZE_WORD); // 7 - (-5)
		expect_store(32'h0001_0208, 32'h0000_0070, MEM_SIZE_WORD);
		expect_store(32'h0001_020c, 32'hffff_fffd, MEM_SIZE_WORD);
		expect_store(32'h0001_0210, 32'h0000_000f, MEM_SIZE_WORD);
		expect_store(32'h0001_0214, 32'h0000_0001, MEM_SIZE_WORD);
		expect_store(32'h0001_0218, 32'h0000_0000, MEM_SIZE_WORD);
		expect_store(32'h0001_021c, 32'hffff_fffc, MEM_SIZE_WORD);
		expect_store(32'h0001_0220, 32'hffff_ffff, MEM_SIZE_WORD);
		expect_store(32'h0001_0224, 32'h0000_0003, MEM_SIZE_WORD);
		expect_store(32'h0001_0228, 32'h0001_105c, MEM_SIZE_WORD); // auipc at 0x1005c
		expect_store(32'h0001_022c, 32'hffff_fffb, MEM_SIZE_WORD);
		expect_store(32'h0001_0230, 32'hffff_fffb, MEM_SIZE_WORD);
		expect_store(32'h0001_0234, 32'h0000_00fb, MEM_SIZE_WORD);
		expect_store(32'h0001_0238, 32'h0000_fffb, MEM_SIZE_WORD);
		expect_store(32'h0001_023c, 32'h0000_000c, MEM_SIZE_WORD);
		expect_store(32'h0001_0240, 32'h0000_0007, MEM_SIZE_WORD);
		expect_store(32'h0001_0244, 32'h0000_0007, MEM_SIZE_WORD);
		expect_store(32'h0001_0248, 32'h0000_0007, MEM_SIZE_WORD);
		expect_store(32'h0001_024c, 32'h0000_0007, MEM_SIZE_WORD);
		expect_store(32'h0001_0250, 32'h0000_0007, MEM_SIZE_WORD);
		expect_store(32'h0001_0254, 32'h0000_0007, MEM_SIZE_WORD);
		expect_store(32'h0001_0258, 32'h0001_00f0, MEM_SIZE_WORD); // jal link
		expect_store(32'h0001_025c, 32'h0001_0100, MEM_SIZE_WORD); // jalr link
		expect_store(32'h0001_0260, 32'h0000_000c, MEM_SIZE_WORD);
		expect_store(32'h0001_0261, 32'h0000_00fc, MEM_SIZE_BYTE);
		expect_store(32'h0001_0262, 32'h0000_000f, MEM_SIZE_HALF);
		expect_store(32'h0001_0264, 32'h000f_fc0c, MEM_SIZE_WORD); // merged word
		expect_store(32'h0001_0268, 32'h0000_0000, MEM_SIZE_WORD);
		// lb, lh, lbu, lhu, lw and the lw of the merged word
		expect_load(32'h0001_0200, MEM_SIZE_BYTE, 1'b0);
		expect_load(32'h0001_0200, MEM_SIZE_HALF, 1'b0);
		expect_load(32'h0001_0200, MEM_SIZE_BYTE, 1'b1);
		expect_load(32'h0001_0200, MEM_SIZE_HALF, 1'b1);
		expect_load(32'h0001_0204, MEM_SIZE_WORD, 1'b0);
		expect_load(32'h0001_0260, MEM_SIZE_WORD, 1'b0);
	endtask

	// cycle budget follows the program length
	initial begin
		@(negedge clk);
		repeat (prog_q.size() * 3 + 20) @(posedge clk);
		$display("timeout: the expected stores did not all appear");
		$display(">>> FAIL");
		$fatal(1, "watchdog expired");
	end

	initial begin
		int r;
		word_t got_addr;
		word_t got_data;
		mem_size_t got_size;
		clk = 1'b0;
		reset = 1'b1;
		load_count = 0;
		load_program();
		load_expected();
		for (r = 0; r < 3; r++) begin
			@(posedge clk);
			@(negedge clk);
			assert (mem_wr_enable === 1'b0) else begin
				$display("memory write strobe was active during reset");
				$display(">>> FAIL");
				$fatal(1, "write during reset");
			end
		end
		reset = 1'b0;
		check_value("mem_rd_addr_o", mem_rd_addr, RESET_PC);
		check_value("mem_rd_size_o", word_t'(mem_rd_size), word_t'(MEM_SIZE_WORD));

		for (r = 0; r < exp_addr_q.size(); r++) begin
			while (obs_addr_q.size() == 0)
				@(negedge clk);
			got_addr = obs_addr_q.pop_front();
			got_data = obs_data_q.pop_front();
			got_size = obs_size_q.pop_front();
			check_value("mem_wr_addr_o", got_addr, exp_addr_q[r]);
			check_value("mem_wr_size_o", word_t'(got_size), word_t'(exp_size_q[r]));
			check_value("mem_wr_data_o", got_data & size_mask(exp_size_q[r]), exp_data_q[r]);
		end

		if (load_count == ld_addr_q.size()) begin
			$display(">>> PASS");
			$finish;
		end else begin
			$display("not every expected load reached memory");
			$display(">>> FAIL");
			$fatal(1, "missing load");
		end
	end

endmodule

`default_nettype wire

// ==== compile.f ====
logic/rv_isa_pkg.sv
logic/core_ctrl_pkg.sv
logic/control.sv
logic/regfile.sv
logic/alu.sv
logic/compare_unit.sv
logic/datapath.sv
tests/datapath_chk.sv
tests/datapath_tb.sv

// ==== run.sh ====
#!/bin/sh
# build and run the core testbench with Verilator
cd "$(dirname "$0")" &&
verilator --binary --timing -Wno-fatal --top-module datapath_tb -f compile.f -o sim_datapath &&
./obj_dir/sim_datapath | tee /dev/stderr | grep -F ">>> PASS" > /dev/null &&
echo "simulation passed" ||
{ echo "simulation failed"; exit 1; }
